// ==== common/nunchuck_pkg.sv ====
`default_nettype none

package nunchuck_pkg;

	// bus and device
	localparam logic [6:0] NUNCHUCK_ADDR = 7'h52;	// fixed nunchuck slave address
	localparam int MAX_BYTES = 6;			// longest transfer, one full report

	// timing, in i2c_clock cycles
	localparam int SCL_QUARTER = 4;		// one quarter of an scl period
	localparam int POLL_PERIOD = 3000;	// spacing of poll ticks

	// one transfer request for the byte-level master
	typedef struct packed {
		logic write;			// 1 = write, 0 = read
		logic [7:0] reg_addr;	// register byte after the address (writes only)
		logic [2:0] num_bytes;	// data bytes to move
		logic [7:0] data0;		// payload byte for writes
	} i2c_cmd_t;

	// raw report, index 0 is the first byte on the wire
	typedef logic [MAX_BYTES-1:0][7:0] raw_frame_t;

	// decoded controls
	typedef struct packed {
		logic [7:0] stick_x;
		logic [7:0] stick_y;
		logic [9:0] accel_x;	// 8 msbs from their own byte, 2 lsbs from byte 5
		logic [9:0] accel_y;
		logic [9:0] accel_z;
		logic z;				// 1 = pressed
		logic c;				// 1 = pressed
	} nunchuck_sample_t;

endpackage

`default_nettype wire

// ==== i2c_master/i2c_master.sv ====
`timescale 1ns/1ns
`default_nettype none

module i2c_master (
	input logic i2c_clock,
	input logic rst,
	input logic cmd_start,
	input nunchuck_pkg::i2c_cmd_t cmd,
	output logic cmd_done,
	output logic nack,
	output nunchuck_pkg::raw_frame_t rd_frame,
	output logic scl,
	inout wire sda
);
	import nunchuck_pkg::*;

	localparam int QW = $clog2(SCL_QUARTER);

	typedef enum logic [2:0] {
		bus_idle,
		bus_start,
		bus_bit,	// eight data bits
		bus_ack,	// ninth bit, either direction
		bus_stop
	} bus_state_t;

	bus_state_t state;
	logic [QW-1:0] qcnt;		// cycles inside a quarter
	logic [1:0] qph;			// quarter inside a bit
	logic q_tick;				// last cycle of a quarter
	i2c_cmd_t cmd_r;
	logic [3:0] byte_cnt;		// 0 is the address byte
	logic [3:0] last_byte;
	logic [2:0] bit_cnt;
	logic [7:0] tx_sh;
	logic [7:0] rx_sh;
	logic [7:0] next_tx;
	logic rx_mode;				// current byte comes from the slave
	logic scl_low;
	logic sda_low;

	assign q_tick = (state != bus_idle) && (qcnt == QW'(SCL_QUARTER - 1));
	assign rx_mode = !cmd_r.write && (byte_cnt != 4'd0);
	assign last_byte = cmd_r.write ? 4'(cmd_r.num_bytes) + 4'd1 : 4'(cmd_r.num_bytes);
	assign next_tx = (byte_cnt == 4'd0) ? cmd_r.reg_addr : cmd_r.data0;

	// open drain, pull low or let go
	assign scl = scl_low ? 1'b0 : 1'bz;
	assign sda = sda_low ? 1'b0 : 1'bz;

	// each bit is four quarters; actions fire at the end of a quarter
	// q0 scl low, q1/q2 scl high, sample at end of q1, q3 scl low again
	always_ff @(posedge i2c_clock or posedge rst) begin
		if (rst) begin
			state <= bus_idle;
			qcnt <= '0;
			qph <= 2'd0;
			cmd_r <= '0;
			byte_cnt <= 4'd0;
			bit_cnt <= 3'd0;
			tx_sh <= 8'h00;
			scl_low <= 1'b0;
			sda_low <= 1'b0;
			cmd_done <= 1'b0;
			nack <= 1'b0;
		end else begin
			cmd_done <= 1'b0;
			if (state == bus_idle) begin
				qcnt <= '0;
				qph <= 2'd0;
				if (cmd_start) begin
					cmd_r <= cmd;
					tx_sh <= {NUNCHUCK_ADDR, ~cmd.write};	// r/w bit, 1 = read
					byte_cnt <= 4'd0;
					bit_cnt <= 3'd7;
					nack <= 1'b0;
					state <= bus_start;
				end
			end else begin
				qcnt <= q_tick ? '0 : qcnt + 1'b1;
				if (q_tick) begin
					qph <= qph + 2'd1;
					case (state)
						bus_start: begin
							case (qph)
								2'd0: sda_low <= 1'b1;		// start, sda falls under high scl
								2'd2: scl_low <= 1'b1;
								2'd3: begin
									sda_low <= ~tx_sh[7];	// address msb
									state <= bus_bit;
								end
								default: ;
							endcase
						end
						bus_bit: begin
							case (qph)
								2'd0: scl_low <= 1'b0;
								2'd2: scl_low <= 1'b1;
								2'd3: begin
									if (bit_cnt == 3'd0) begin
										// release for slave ack, or ack/nack a read byte
										sda_low <= rx_mode && (byte_cnt != last_byte);
										state <= bus_ack;
									end else begin
										bit_cnt <= bit_cnt - 3'd1;
										tx_sh <= {tx_sh[6:0], 1'b0};
										sda_low <= !rx_mode && !tx_sh[6];
									end
								end
								default: ;
							endcase
						end
						bus_ack: begin
							case (qph)
								2'd0: scl_low <= 1'b0;
								2'd1: begin
									if (!rx_mode && sda)
										nack <= 1'b1;		// slave left sda high
								end
								2'd2: scl_low <= 1'b1;
								2'd3: begin
									if (nack || byte_cnt == last_byte) begin
										sda_low <= 1'b1;	// hold low for the stop
										state <= bus_stop;
									end else begin
										byte_cnt <= byte_cnt + 4'd1;
										bit_cnt <= 3'd7;
										tx_sh <= next_tx;
										sda_low <= cmd_r.write && !next_tx[7];
										state <= bus_bit;
									end
								end
							endcase
						end
						bus_stop: begin
							case (qph)
								2'd0: scl_low <= 1'b0;
								2'd1: sda_low <= 1'b0;		// stop, sda rises under high scl
								2'd3: begin
									cmd_done <= 1'b1;
									state <= bus_idle;
								end
								default: ;
							endcase
						end
						default: state <= bus_idle;
					endcase
				end
			end
		end
	end

	// receive path, middle of scl high
	always_ff @(posedge i2c_clock) begin
		if (q_tick && qph == 2'd1) begin
			if (state == bus_bit)
				rx_sh <= {rx_sh[6:0], sda};		// msb first
			if (state == bus_ack && rx_mode)
				rd_frame[3'(byte_cnt - 4'd1)] <= rx_sh;	// wire order
		end
	end

endmodule

`default_nettype wire

// ==== nunchuck_driver/nunchuck_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module nunchuck_sequencer (
	input logic i2c_clock,
	input logic rst,
	input logic poll_tick,
	input logic cmd_done,
	input logic nack,
	input nunchuck_pkg::raw_frame_t rd_frame,
	output logic cmd_start,
	output nunchuck_pkg::i2c_cmd_t cmd,
	output nunchuck_pkg::raw_frame_t frame,
	output logic sample_valid,
	output logic link_fault
);
	import nunchuck_pkg::*;

	typedef enum logic [2:0] {
		idle,
		init_encrypt,	// F0 <- 55
		init_plain,		// FB <- 00
		set_pointer,	// pointer back to 00
		read_frame		// six byte report
	} seq_state_t;

	seq_state_t state;
	logic issued;		// command of the current state already sent
	logic init_done;	// plain mode handshake completed

	// command table, held steady for the whole state
	always_comb begin
		case (state)
			init_encrypt: cmd = '{write: 1'b1, reg_addr: 8'hF0, num_bytes: 3'd1, data0: 8'h55};
			init_plain:   cmd = '{write: 1'b1, reg_addr: 8'hFB, num_bytes: 3'd1, data0: 8'h00};
			set_pointer:  cmd = '{write: 1'b1, reg_addr: 8'h00, num_bytes: 3'd0, data0: 8'h00};
			read_frame:   cmd = '{write: 1'b0, reg_addr: 8'h00, num_bytes: 3'(MAX_BYTES),
			                      data0: 8'h00};
			default:      cmd = '0;
		endcase
	end

	always_ff @(posedge i2c_clock or posedge rst) begin
		if (rst) begin
			state <= idle;
			issued <= 1'b0;
			init_done <= 1'b0;
			cmd_start <= 1'b0;
			sample_valid <= 1'b0;
			link_fault <= 1'b0;
			frame <= '0;	// zero sample until the first read
		end else begin
			cmd_start <= 1'b0;
			sample_valid <= 1'b0;
			case (state)
				idle: begin
					// ticks outside idle are simply lost
					if (poll_tick)
						state <= init_done ? set_pointer : init_encrypt;
				end
				default: begin
					if (!issued) begin
						cmd_start <= 1'b1;	// one pulse per command state
						issued <= 1'b1;
					end else if (cmd_done) begin
						issued <= 1'b0;
						if (nack) begin
							// drop the poll, redo the handshake next time
							init_done <= 1'b0;
							link_fault <= 1'b1;
							state <= idle;
						end else begin
							case (state)
								init_encrypt: state <= init_plain;
								init_plain: begin
									init_done <= 1'b1;
									state <= set_pointer;
								end
								set_pointer: state <= read_frame;
								read_frame: begin
									frame <= rd_frame;		// sample updates with this edge
									sample_valid <= 1'b1;
									link_fault <= 1'b0;
									state <= idle;
								end
								default: state <= idle;
							endcase
						end
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== nunchuck_driver/poll_timer.sv ====
`timescale 1ns/1ns
`default_nettype none

module poll_timer (
	input logic i2c_clock,
	input logic rst,
	output logic poll_tick
);
	import nunchuck_pkg::*;

	localparam int CNT_W = $clog2(POLL_PERIOD);

	logic [CNT_W-1:0] cnt;	// cycles since last wrap

	// free running, one tick per period
	always_ff @(posedge i2c_clock or posedge rst) begin
		if (rst) begin
			cnt <= '0;
			poll_tick <= 1'b0;
		end else begin
			if (cnt == CNT_W'(POLL_PERIOD - 1)) begin
				cnt <= '0;
				poll_tick <= 1'b1;	// registered at the wrap
			end else begin
				cnt <= cnt + 1'b1;
				poll_tick <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== nunchuck_poll.f ====
common/nunchuck_pkg.sv
nunchuck_driver/poll_timer.sv
nunchuck_driver/nunchuck_sequencer.sv
i2c_master/i2c_master.sv
source/nunchuck_translator.sv
source/nunchuck_top.sv
verif/nunchuck_slave_model.sv
verif/nunchuck_sva.sv
verif/tb_nunchuck_top.sv

// ==== source/nunchuck_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module nunchuck_top (
	input logic i2c_clock,
	input logic rst,
	output logic scl,
	inout wire sda,
	output nunchuck_pkg::nunchuck_sample_t sample,
	output logic sample_valid,
	output logic link_fault
);
	import nunchuck_pkg::*;

	logic poll_tick;
	logic cmd_start;
	logic cmd_done;
	logic nack;
	i2c_cmd_t cmd;
	raw_frame_t rd_frame;	// straight from the master
	raw_frame_t frame;		// latched on a good read

	poll_timer u_poll_timer (
		.i2c_clock (i2c_clock),
		.rst       (rst),
		.poll_tick (poll_tick)
	);

	nunchuck_sequencer u_sequencer (
		.i2c_clock    (i2c_clock),
		.rst          (rst),
		.poll_tick    (poll_tick),
		.cmd_done     (cmd_done),
		.nack         (nack),
		.rd_frame     (rd_frame),
		.cmd_start    (cmd_start),
		.cmd          (cmd),
		.frame        (frame),
		.sample_valid (sample_valid),
		.link_fault   (link_fault)
	);

	i2c_master u_i2c_master (
		.i2c_clock (i2c_clock),
		.rst       (rst),
		.cmd_start (cmd_start),
		.cmd       (cmd),
		.cmd_done  (cmd_done),
		.nack      (nack),
		.rd_frame  (rd_frame),
		.scl       (scl),
		.sda       (sda)
	);

	nunchuck_translator u_translator (
		.frame  (frame),
		.sample (sample)
	);

endmodule

`default_nettype wire

// ==== source/nunchuck_translator.sv ====
`timescale 1ns/1ns
`default_nettype none

module nunchuck_translator (
	input nunchuck_pkg::raw_frame_t frame,
	output nunchuck_pkg::nunchuck_sample_t sample
);

	// plain mode report layout
	// byte 5: [7:6] az lsbs, [5:4] ay lsbs, [3:2] ax lsbs, [1] c_n, [0] z_n
	always_comb begin
		sample.stick_x = frame[0];
		sample.stick_y = frame[1];

		sample.accel_x = {frame[2], frame[5][3:2]};	// 10 bit values
		sample.accel_y = {frame[3], frame[5][5:4]};
		sample.accel_z = {frame[4], frame[5][7:6]};

		// buttons are active low on the wire
		sample.z = ~frame[5][0];
		sample.c = ~frame[5][1];
	end

endmodule

`default_nettype wire

// ==== verif/nunchuck_slave_model.sv ====
`timescale 1ns/1ns
`default_nettype none

module nunchuck_slave_model (
	input logic rst,
	input wire scl,
	inout wire sda,
	input logic nack_enable,					// withhold the address ack
	input nunchuck_pkg::raw_frame_t serve_frame
);
	import nunchuck_pkg::*;

	logic sda_low;
	logic in_xfer;		// between start and stop
	logic in_ack;		// inside the ninth bit
	logic addressed;
	logic rw;			// 1 = read
	logic tx_on;		// slave drives data bits
	logic read_active;	// read accepted, bytes being served
	logic has_data;
	logic [6:0] addr7;
	logic [7:0] sh;
	logic [7:0] wreg;
	logic [7:0] wdata;
	int bitc;
	int byte_idx;
	raw_frame_t served;

	// write log entry: {addr7, has_data, reg, data}
	logic [23:0] wr_log[$];
	raw_frame_t rd_log[$];

	assign sda = sda_low ? 1'b0 : 1'bz;

	initial begin
		sda_low = 1'b0;
		in_xfer = 1'b0;
		read_active = 1'b0;
	end

	// logs survive reset, bus state does not
	always @(posedge rst) begin
		sda_low = 1'b0;
		in_xfer = 1'b0;
		in_ack = 1'b0;
		tx_on = 1'b0;
		read_active = 1'b0;
	end

	// start, sda falls under high scl
	always @(negedge sda) begin
		if (!rst && scl === 1'b1) begin
			in_xfer = 1'b1;
			in_ack = 1'b0;
			tx_on = 1'b0;
			addressed = 1'b0;
			has_data = 1'b0;
			bitc = 0;
			byte_idx = 0;
		end
	end

	// stop, sda rises under high scl
	always @(posedge sda) begin
		if (!rst && in_xfer && scl === 1'b1) begin
			in_xfer = 1'b0;
			sda_low = 1'b0;
			if (addressed && !rw)
				wr_log.push_back({addr7, has_data, wreg, wdata});
			if (addressed && rw)
				rd_log.push_back(served);
			read_active = 1'b0;
		end
	end

	always @(posedge scl) begin
		if (!rst && in_xfer) begin
			if (in_ack) begin
				if (tx_on && sda !== 1'b0)
					tx_on = 1'b0;	// master nacked, last byte
			end else if (bitc < 8) begin
				if (!tx_on)
					sh = {sh[6:0], (sda === 1'b0) ? 1'b0 : 1'b1};
				bitc++;
			end
		end
	end

	// all slave drive changes happen while scl is low
	always @(negedge scl) begin
		if (!rst && in_xfer) begin
			if (in_ack) begin
				in_ack = 1'b0;
				bitc = 0;
				byte_idx++;
				sda_low = 1'b0;
				if (tx_on && byte_idx > MAX_BYTES)
					tx_on = 1'b0;
				if (tx_on)
					sda_low = ~served[byte_idx-1][7];
			end else if (bitc == 8) begin
				in_ack = 1'b1;
				if (byte_idx == 0) begin
					addr7 = sh[7:1];
					rw = sh[0];
					addressed = (sh[7:1] == NUNCHUCK_ADDR) && !nack_enable;
					sda_low = addressed;
					if (addressed && rw) begin
						served = serve_frame;	// one frame per read
						tx_on = 1'b1;
						read_active = 1'b1;
					end
				end else if (tx_on) begin
					sda_low = 1'b0;		// master's ack slot
				end else begin
					if (byte_idx == 1)
						wreg = sh;
					else if (byte_idx == 2) begin
						wdata = sh;
						has_data = 1'b1;
					end
					sda_low = addressed;
				end
			end else if (tx_on && bitc < 8) begin
				sda_low = ~served[byte_idx-1][7-bitc];	// msb first
			end
		end
	end

endmodule

`default_nettype wire

// ==== verif/nunchuck_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

module nunchuck_sva (
	input logic i2c_clock,
	input logic rst,
	input logic cmd_start,
	input logic busy,			// master away from idle
	input logic cmd_done,
	input logic sample_valid,
	input logic in_bits,		// data bit or ack slot on the bus
	input logic scl_high,
	input logic sda_line
);

	a_start_idle: assert property (@(posedge i2c_clock) disable iff (rst)
		cmd_start |-> !busy)
		else $error("cmd_start while the master is busy");

	a_done_pulse: assert property (@(posedge i2c_clock) disable iff (rst)
		cmd_done |=> !cmd_done)
		else $error("cmd_done longer than one cycle");

	a_valid_pulse: assert property (@(posedge i2c_clock) disable iff (rst)
		sample_valid |=> !sample_valid)
		else $error("sample_valid longer than one cycle");

	// start and stop live outside the bit states
	a_sda_stable: assert property (@(posedge i2c_clock) disable iff (rst)
		(in_bits && $past(in_bits) && scl_high && $past(scl_high)) |-> $stable(sda_line))
		else $error("sda changed while scl high inside a bit");

endmodule

bind i2c_master nunchuck_sva u_master_sva (
	.i2c_clock    (i2c_clock),
	.rst          (rst),
	.cmd_start    (cmd_start),
	.busy         (state != bus_idle),
	.cmd_done     (cmd_done),
	.sample_valid (1'b0),
	.in_bits      (state == bus_bit || state == bus_ack),
	.scl_high     (!scl_low),
	.sda_line     (sda)
);

bind nunchuck_sequencer nunchuck_sva u_seq_sva (
	.i2c_clock    (i2c_clock),
	.rst          (rst),
	.cmd_start    (1'b0),
	.busy         (1'b0),
	.cmd_done     (cmd_done),
	.sample_valid (sample_valid),
	.in_bits      (1'b0),
	.scl_high     (1'b1),
	.sda_line     (1'b1)
);

`default_nettype wire

// ==== verif/tb_nunchuck_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_nunchuck_top;
	import nunchuck_pkg::*;

	localparam int RAND_POLLS = 20;
	localparam int PLANNED_POLLS = 1 + RAND_POLLS + 3 + 3;
	localparam int WAIT_LIMIT = 2 * POLL_PERIOD;	// cycles, any single wait

	logic i2c_clock;
	logic rst;
	logic nack_enable;
	raw_frame_t serve_frame;
	wire scl_w;
	wire sda_w;
	nunchuck_sample_t sample;
	logic sample_valid;
	logic link_fault;

	int seed;
	int test_err;
	int stable_err;
	int gap_err;
	int tests_passed;
	int tests_failed;
	longint cycle_cnt;
	longint last_cyc;
	nunchuck_sample_t held;		// sample as of the last pulse
	logic track;

	pullup (scl_w);
	pullup (sda_w);

	nunchuck_top UUT (
		.i2c_clock    (i2c_clock),
		.rst          (rst),
		.scl          (scl_w),
		.sda          (sda_w),
		.sample       (sample),
		.sample_valid (sample_valid),
		.link_fault   (link_fault)
	);

	nunchuck_slave_model slave (
		.rst         (rst),
		.scl         (scl_w),
		.sda         (sda_w),
		.nack_enable (nack_enable),
		.serve_frame (serve_frame)
	);

	initial i2c_clock = 1'b0;
	always #50 i2c_clock = ~i2c_clock;

	always @(posedge i2c_clock) cycle_cnt++;

	// sample must hold between pulses
	always @(negedge i2c_clock) begin
		if (track && !rst) begin
			if (sample_valid)
				held = sample;
			else
				assert (sample == held) else begin
					$display("[FAIL] %0t sample changed without sample_valid", $time);
					stable_err++;
				end
		end
	end

	// watchdog
	initial begin
		#((PLANNED_POLLS + 4) * POLL_PERIOD * 100);
		$display("timeout, the tests did not finish in the expected time");
		$display("Simulation FAILED");
		$finish;
	end

	function automatic nunchuck_sample_t expect_sample(input raw_frame_t f);
		nunchuck_sample_t s;
		s.stick_x = f[0];
		s.stick_y = f[1];
		s.accel_x = {f[2], f[5][3], f[5][2]};
		s.accel_y = {f[3], f[5][5], f[5][4]};
		s.accel_z = {f[4], f[5][7], f[5][6]};
		s.z = !f[5][0];	// wire is active low
		s.c = !f[5][1];
		return s;
	endfunction

	task automatic report_fail(input string msg);
		$display("[FAIL] %0t %s", $time, msg);
		test_err++;
	endtask

	task automatic new_frame();
		for (int i = 0; i < MAX_BYTES; i++)
			serve_frame[i] = 8'($random(seed));
	endtask

	// returns at the falling edge where sample_valid is high
	task automatic wait_valid(output bit got);
		int n;
		got = 1'b0;
		n = 0;
		while (!got && n < WAIT_LIMIT) begin
			@(negedge i2c_clock);
			got = sample_valid;
			n++;
		end
		if (!got) begin
			$display("no sample_valid arrived within two poll periods at %0t", $time);
			test_err++;
		end
	endtask

	task automatic check_sample();
		raw_frame_t f;
		f = slave.rd_log[slave.rd_log.size()-1];
		assert (sample == expect_sample(f))
			else report_fail($sformatf("sample %h, expected %h", sample, expect_sample(f)));
		new_frame();	// next read serves fresh bytes
	endtask

	task automatic check_write(input int idx, input logic [7:0] rg, input logic has,
		input logic [7:0] data);
		logic [23:0] e;
		if (slave.wr_log.size() <= idx) begin
			report_fail($sformatf("write log entry %0d missing", idx));
		end else begin
			e = slave.wr_log[idx];
			assert (e[23:17] == NUNCHUCK_ADDR && e[15:8] == rg && e[16] == has
				&& (!has || e[7:0] == data))
				else report_fail($sformatf("write %0d is %h, expected reg %h data %h",
					idx, e, rg, data));
		end
	endtask

	task automatic check_init(input int base);
		check_write(base, 8'hF0, 1'b1, 8'h55);
		check_write(base + 1, 8'hFB, 1'b1, 8'h00);
		check_write(base + 2, 8'h00, 1'b0, 8'h00);	// pointer only
	endtask

	task automatic end_test(input string name);
		if (test_err == 0) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, test_err);
		end
		test_err = 0;
	endtask

	initial begin
		bit got;
		int wsz;
		int n;
		seed = 32'h45f2;
		test_err = 0;
		stable_err = 0;
		gap_err = 0;
		tests_passed = 0;
		tests_failed = 0;
		cycle_cnt = 0;
		track = 1'b0;
		rst = 1'b1;
		nack_enable = 1'b0;
		new_frame();
		repeat (16) @(negedge i2c_clock);
		rst = 1'b0;

		// 1: init order after reset
		wait_valid(got);
		check_init(0);
		if (got)
			check_sample();
		held = sample;
		track = 1'b1;
		last_cyc = cycle_cnt;
		end_test("1 init order");

		// 2 and 3: random frames, fixed spacing
		for (int i = 0; i < RAND_POLLS; i++) begin
			wsz = slave.wr_log.size();
			wait_valid(got);
			if (got) begin
				check_sample();
				assert (slave.wr_log.size() == wsz + 1)
					else report_fail("init repeated or pointer write missing");
				check_write(wsz, 8'h00, 1'b0, 8'h00);
				// first pulse came from the longer init poll
				if (i > 0) begin
					assert (cycle_cnt - last_cyc == POLL_PERIOD) else begin
						$display("[FAIL] %0t pulse gap %0d cycles", $time,
							cycle_cnt - last_cyc);
						gap_err++;
					end
				end
				last_cyc = cycle_cnt;
			end
		end
		end_test("2 random samples");
		test_err = gap_err + stable_err;
		stable_err = 0;
		end_test("3 pulse spacing and hold");

		// 4: one nacked poll
		nack_enable = 1'b1;
		n = 0;
		while (!link_fault && n < WAIT_LIMIT) begin
			@(negedge i2c_clock);
			assert (!sample_valid) else report_fail("sample_valid during nacked poll");
			n++;
		end
		if (!link_fault) begin
			$display("link_fault never rose while the slave withheld its ack");
			test_err++;
		end
		nack_enable = 1'b0;
		wsz = slave.wr_log.size();
		wait_valid(got);
		check_init(wsz);
		if (got) begin
			check_sample();
			assert (!link_fault) else report_fail("link_fault still set after good read");
		end
		test_err += stable_err;
		stable_err = 0;
		end_test("4 nack recovery");

		// 5: reset in the middle of the recovery read, link_fault still high
		nack_enable = 1'b1;
		n = 0;
		while (!link_fault && n < WAIT_LIMIT) begin
			@(negedge i2c_clock);
			n++;
		end
		nack_enable = 1'b0;
		if (!link_fault) begin
			$display("link_fault never rose before the mid-read reset");
			test_err++;
		end
		n = 0;
		while (!slave.read_active && n < WAIT_LIMIT) begin
			@(negedge i2c_clock);
			n++;
		end
		if (!slave.read_active) begin
			$display("no read started before the mid-read reset");
			test_err++;
		end
		repeat (40) @(negedge i2c_clock);
		track = 1'b0;
		rst = 1'b1;
		@(negedge i2c_clock);
		assert (scl_w === 1'b1 && sda_w === 1'b1) else report_fail("bus not released in reset");
		assert (!link_fault && !sample_valid) else report_fail("outputs not cleared in reset");
		repeat (15) @(negedge i2c_clock);
		rst = 1'b0;
		wsz = slave.wr_log.size();
		wait_valid(got);
		check_init(wsz);
		if (got)
			check_sample();
		test_err += stable_err;
		stable_err = 0;
		end_test("5 reset mid-read");

		$display("tests passed %0d, failed %0d", tests_passed, tests_failed);
		if (tests_failed == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire
